/* compile.f */
+incdir+verilog
verilog/wconv_types_pkg.sv
verilog/wconv_ctrl_pkg.sv
verilog/ram_port_if.sv
verilog/wconv_bank_ram.sv
verilog/wconv_asym_ram.sv
verilog/wconv_ptr_counter.sv
verilog/wconv_ctrl_fsm.sv
verilog/wconv_top.sv
testbench/tb_wconv.sv

/* testbench/tb_wconv.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_wconv import wconv_types_pkg::*; ();

   // 200 bytes at about 20 cycles each plus the stalled phase
   localparam int TIMEOUT_CYCLES = 200 * 20 + 4000;
   localparam int STREAM_BYTES   = 200;
   localparam int HOLD_BYTES     = 80;
   // 64 buffered bytes plus the word already popped
   localparam int HOLD_LIMIT     = 68;

   logic  clk;
   logic  rst_n;
   logic  in_req;
   byte_t in_byte;
   logic  in_ack;
   logic  out_req;
   logic  out_ack;
   word_t out_word;

   integer seed = 32'ha21a_b259;
   int     cycle_count = 0;
   int     err_data = 0;
   int     err_proto = 0;
   int     err_other = 0;

   // accepted bytes in arrival order
   byte_t  sb_q[$];
   word_t  exp_word = '0;
   logic   exp_valid = 1'b0;
   int     words_rx = 0;
   int     hold_count = 0;
   logic   in_ack_q = 1'b0;
   logic   out_req_q = 1'b0;
   logic   seen_req = 1'b0;
   logic   ack_enable;
   logic   hold_mode;
   logic   stall_window;

   wconv_top i_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_req  (in_req),
      .in_byte (in_byte),
      .in_ack  (in_ack),
      .out_req (out_req),
      .out_ack (out_ack),
      .out_word(out_word)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int rand_delay();
      return $unsigned($random(seed)) % 8;
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_words(input int n);
      while (words_rx < n) begin
         @(negedge clk);
      end
   endtask

   // sends one byte over the four-phase handshake
   task automatic send_byte(input byte_t b);
      idle_cycles(rand_delay());
      @(negedge clk);
      in_byte = b;
      in_req  = 1'b1;
      do begin
         @(negedge clk);
      end while (!in_ack);
      in_req = 1'b0;
      while (in_ack) begin
         @(negedge clk);
      end
   endtask

   task automatic receive_words();
      forever begin
         @(negedge clk);
         if (out_req && ack_enable) begin
            idle_cycles(rand_delay());
            out_ack = 1'b1;
            while (out_req) begin
               @(negedge clk);
            end
            out_ack = 1'b0;
         end
      end
   endtask

   // waits for a full buffer, then keeps the next request pending
   task automatic hold_stall();
      int waited;
      waited = 0;
      while (hold_count < HOLD_LIMIT && waited < 2000) begin
         @(negedge clk);
         waited++;
      end
      if (hold_count < HOLD_LIMIT) begin
         err_other++;
         $display("%0t: only %0d bytes accepted while out_ack was withheld", $time, hold_count);
      end
      // window opens once the next byte is requested
      while (!in_req) begin
         @(negedge clk);
      end
      stall_window = 1'b1;
      idle_cycles(200);
      stall_window = 1'b0;
      if (!in_req) begin
         err_other++;
         $display("%0t: no byte request was pending at the end of the stall", $time);
      end
      hold_mode  = 1'b0;
      ack_enable = 1'b1;
   endtask

   // monitor sees the values from before the edge
   always @(posedge clk) begin
      if (in_req) begin
         seen_req = 1'b1;
      end
      if (in_ack && !in_ack_q) begin
         sb_q.push_back(in_byte);
         if (hold_mode) begin
            hold_count++;
         end
      end
      if (!out_req && out_req_q) begin
         if (sb_q.size() >= 4) begin
            repeat (4) void'(sb_q.pop_front());
         end
         words_rx++;
      end
      if (!hold_mode) begin
         hold_count = 0;
      end
      in_ack_q  = in_ack;
      out_req_q = out_req;
      exp_valid = (sb_q.size() >= 4);
      // earliest byte in the lowest lane
      if (exp_valid) begin
         exp_word = {sb_q[3], sb_q[2], sb_q[1], sb_q[0]};
      end
   end

   a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      !seen_req |-> (!in_ack && !out_req))
      else begin
         err_proto++;
         $display("%0t: handshake output raised before any request", $time);
      end

   a_in_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
      (in_ack && in_req) |=> in_ack)
      else begin
         err_proto++;
         $display("%0t: in_ack dropped while in_req was still high", $time);
      end

   a_out_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (out_req && !out_ack) |=> out_req)
      else begin
         err_proto++;
         $display("%0t: out_req dropped before out_ack", $time);
      end

   a_out_word_stable: assert property (@(posedge clk) disable iff (!rst_n)
      out_req |=> (!out_req || $stable(out_word)))
      else begin
         err_data++;
         $display("%0t: out_word changed while out_req was high", $time);
      end

   a_word_available: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(out_req) |-> exp_valid)
      else begin
         err_data++;
         $display("%0t: word offered with fewer than four bytes accepted", $time);
      end

   a_word_value: assert property (@(posedge clk) disable iff (!rst_n)
      ($rose(out_req) && exp_valid) |-> (out_word == exp_word))
      else begin
         err_data++;
         $display("[ERROR] %0t out_word: got %h, expected %h", $time, out_word, exp_word);
      end

   a_hold_limit: assert property (@(posedge clk) disable iff (!rst_n)
      hold_count <= HOLD_LIMIT)
      else begin
         err_proto++;
         $display("%0t: %0d bytes accepted with out_ack withheld", $time, hold_count);
      end

   a_stall_no_ack: assert property (@(posedge clk) disable iff (!rst_n)
      stall_window |-> !$rose(in_ack))
      else begin
         err_proto++;
         $display("%0t: byte acknowledged into a full buffer", $time);
      end

   initial begin
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      int i;
      rst_n        = 1'b0;
      in_req       = 1'b0;
      in_byte      = '0;
      out_ack      = 1'b0;
      ack_enable   = 1'b1;
      hold_mode    = 1'b0;
      stall_window = 1'b0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      fork
         receive_words();
      join_none
      idle_cycles(10);

      for (i = 0; i < STREAM_BYTES; i++) begin
         send_byte(byte_t'($random(seed)));
      end
      wait_words(STREAM_BYTES / 4);
      idle_cycles(4);

      // receiver stalls while the buffer and out_word fill up
      ack_enable = 1'b0;
      hold_mode  = 1'b1;
      fork
         begin
            for (i = 0; i < HOLD_BYTES; i++) begin
               send_byte(byte_t'($random(seed)));
            end
         end
         hold_stall();
      join
      wait_words((STREAM_BYTES + HOLD_BYTES) / 4);
      idle_cycles(10);

      if (sb_q.size() != 0 || words_rx != (STREAM_BYTES + HOLD_BYTES) / 4) begin
         err_other++;
         $display("%0d words received, %0d bytes never delivered", words_rx, sb_q.size());
      end
      $display("words %0d, data errors %0d, protocol errors %0d, other errors %0d",
               words_rx, err_data, err_proto, err_other);
      if (err_data + err_proto + err_other == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/wconv_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wconv_params.svh"

module wconv_top import wconv_types_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  in_req,
   input  byte_t in_byte,
   output logic  in_ack,
   output logic  out_req,
   input  logic  out_ack,
   output word_t out_word
);

   logic space;
   logic word_ready;

   ram_port_if i_port ();

   wconv_ctrl_fsm i_ctrl_fsm (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_req    (in_req),
      .in_byte   (in_byte),
      .in_ack    (in_ack),
      .out_req   (out_req),
      .out_ack   (out_ack),
      .space     (space),
      .word_ready(word_ready),
      .port      (i_port.ctrl)
   );

   wconv_ptr_counter i_ptr_counter (
      .clk       (clk),
      .rst_n     (rst_n),
      .port      (i_port.ptr),
      .space     (space),
      .word_ready(word_ready)
   );

   // four byte banks behind one word read port
   wconv_asym_ram #(
      .W_DATA_W(`BYTE_W),
      .R_DATA_W(`WORD_W),
      .ADDR_W  (`BUF_ADDR_W)
   ) i_asym_ram (
      .clk(clk),
      .mem(i_port.mem)
   );

   assign out_word = i_port.r_data;

endmodule

`default_nettype wire

/* verilog/wconv_ctrl_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module wconv_ctrl_fsm import wconv_types_pkg::*, wconv_ctrl_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_req,
   input  byte_t    in_byte,
   output logic     in_ack,
   output logic     out_req,
   input  logic     out_ack,
   input  logic     space,
   input  logic     word_ready,
   ram_port_if.ctrl port
);

   in_state_e  in_state;
   out_state_e out_state;

   // input side, waits for room before taking the byte
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_state <= in_idle;
      end else begin
         case (in_state)
            in_idle: begin
               if (in_req && space) begin
                  in_state <= in_write;
               end
            end
            in_write: begin
               in_state <= in_ack_hold;
            end
            in_ack_hold: begin
               // four-phase return, ack drops after req
               if (!in_req) begin
                  in_state <= in_idle;
               end
            end
            default: in_state <= in_idle;
         endcase
      end
   end

   // output side, the word is popped before req goes out
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_state <= out_idle;
      end else begin
         case (out_state)
            out_idle: begin
               if (word_ready) begin
                  out_state <= out_read;
               end
            end
            out_read: begin
               out_state <= out_req_hold;
            end
            out_req_hold: begin
               if (out_ack) begin
                  out_state <= out_ack_wait;
               end
            end
            out_ack_wait: begin
               if (!out_ack) begin
                  out_state <= out_idle;
               end
            end
            default: out_state <= out_idle;
         endcase
      end
   end

   assign port.w_en   = (in_state == in_write);
   assign port.w_data = in_byte;
   assign in_ack      = (in_state == in_ack_hold);

   // read data lands on the same edge that raises req
   assign port.r_en   = (out_state == out_read);
   assign out_req     = (out_state == out_req_hold);

   a_w_en_single: assert property (
      @(posedge clk) disable iff (!rst_n) port.w_en |=> !port.w_en
   ) else $error("buffer write strobe held for two cycles");

   a_out_req_hold: assert property (
      @(posedge clk) disable iff (!rst_n) (out_req && !out_ack) |=> out_req
   ) else $error("out_req dropped before out_ack");

endmodule

`default_nettype wire

/* verilog/wconv_ptr_counter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wconv_params.svh"

module wconv_ptr_counter import wconv_types_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   ram_port_if.ptr port,
   output logic    space,
   output logic    word_ready
);

   localparam fill_t      FULL_FILL  = fill_t'(`BUF_BYTES);
   localparam fill_t      WORD_FILL  = fill_t'(`WORD_W / `BYTE_W);
   localparam byte_addr_t WORD_STEP  = byte_addr_t'(`WORD_W / `BYTE_W);

   byte_addr_t wr_ptr;
   byte_addr_t rd_ptr;
   fill_t      fill;

   // both pointers wrap at the buffer size
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (port.w_en) begin
            wr_ptr <= wr_ptr + byte_addr_t'(1);
         end
         if (port.r_en) begin
            rd_ptr <= rd_ptr + WORD_STEP;
         end
         case ({port.w_en, port.r_en})
            2'b10:   fill <= fill + fill_t'(1);
            2'b01:   fill <= fill - WORD_FILL;
            2'b11:   fill <= fill + fill_t'(1) - WORD_FILL;
            default: fill <= fill;
         endcase
      end
   end

   assign port.w_addr = wr_ptr;
   assign port.r_addr = rd_ptr;
   assign space       = (fill < FULL_FILL);
   assign word_ready  = (fill >= WORD_FILL);

   a_no_push_full: assert property (
      @(posedge clk) disable iff (!rst_n) port.w_en |-> space
   ) else $error("byte written into a full buffer");

   a_no_pop_short: assert property (
      @(posedge clk) disable iff (!rst_n) port.r_en |-> word_ready
   ) else $error("word read with only %0d bytes stored", fill);

endmodule

`default_nettype wire

/* verilog/wconv_asym_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wconv_params.svh"

// narrow serial writes, wide parallel reads
// addresses on both ports are in byte space
module wconv_asym_ram #(
   parameter int W_DATA_W = `BYTE_W,
   parameter int R_DATA_W = `WORD_W,
   parameter int ADDR_W   = `BUF_ADDR_W
) (
   input logic     clk,
   ram_port_if.mem mem
);

   // number of banks and how the byte address splits
   localparam int N           = R_DATA_W / W_DATA_W;
   localparam int N_W         = $clog2(N);
   localparam int SYM_W       = $clog2(W_DATA_W / 8);
   localparam int BANK_ADDR_W = ADDR_W - N_W - SYM_W;
   localparam int WORD_BYTES  = R_DATA_W / 8;

   if ((R_DATA_W % W_DATA_W) != 0 || R_DATA_W < W_DATA_W) begin : g_width_check
      $error("read width %0d is not a multiple of write width %0d", R_DATA_W, W_DATA_W);
   end

   // lanes from all banks, bank 0 lowest
   wire [R_DATA_W-1:0] rd_lanes;

   for (genvar i = 0; i < N; i++) begin : g_bank
      logic bank_w_en;

      if (N == 1) begin : g_single
         assign bank_w_en = mem.w_en;
      end else begin : g_decode
         // low address bits pick the one bank that takes the write
         assign bank_w_en = mem.w_en && (mem.w_addr[SYM_W +: N_W] == N_W'(i));
      end

      wconv_bank_ram #(
         .DATA_W(W_DATA_W),
         .ADDR_W(BANK_ADDR_W)
      ) i_bank (
         .clk   (clk),
         .w_en  (bank_w_en),
         .w_addr(mem.w_addr[ADDR_W-1 -: BANK_ADDR_W]),
         .w_data(mem.w_data),
         .r_en  (mem.r_en),
         .r_addr(mem.r_addr[ADDR_W-1 -: BANK_ADDR_W]),
         .r_data(rd_lanes[i*W_DATA_W +: W_DATA_W])
      );
   end

   assign mem.r_data = rd_lanes;

   // the pointer logic must only ever ask for whole words
   a_r_addr_aligned: assert property (
      @(posedge clk) mem.r_en |-> ((mem.r_addr % WORD_BYTES) == 0)
   ) else $error("unaligned word read at byte address %0d", mem.r_addr);

endmodule

`default_nettype wire

/* verilog/wconv_bank_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module wconv_bank_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk,
   input  logic              w_en,
   input  logic [ADDR_W-1:0] w_addr,
   input  logic [DATA_W-1:0] w_data,
   input  logic              r_en,
   input  logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] r_data
);

   logic [DATA_W-1:0] mem_array [0:(2**ADDR_W)-1];

   always_ff @(posedge clk) begin
      if (w_en) begin
         mem_array[w_addr] <= w_data;
      end
   end

   // output register keeps the last word until the next read
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem_array[r_addr];
      end
   end

endmodule

`default_nettype wire

/* verilog/ram_port_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface ram_port_if import wconv_types_pkg::*; ();

   // write side, one byte per strobe
   logic       w_en;
   byte_addr_t w_addr;
   byte_t      w_data;

   // read side, one word per strobe
   logic       r_en;
   byte_addr_t r_addr;
   word_t      r_data;

   modport ctrl (output w_en, output w_data, output r_en);

   // strobes double as push and pop
   modport ptr (input w_en, input r_en, output w_addr, output r_addr);

   modport mem (input w_en, input w_addr, input w_data, input r_en, input r_addr,
                output r_data);

endinterface

`default_nettype wire

/* verilog/wconv_ctrl_pkg.sv */
`default_nettype none

package wconv_ctrl_pkg;

   // input handshake and buffer write
   typedef enum logic [1:0] {in_idle, in_write, in_ack_hold} in_state_e;

   // buffer read and output handshake
   typedef enum logic [1:0] {out_idle, out_read, out_req_hold, out_ack_wait} out_state_e;

endpackage

`default_nettype wire

/* verilog/wconv_types_pkg.sv */
`default_nettype none

`include "wconv_params.svh"

package wconv_types_pkg;

   // one byte from the sender
   typedef logic [`BYTE_W-1:0] byte_t;

   // one word to the receiver
   typedef logic [`WORD_W-1:0] word_t;

   // buffer address, always counted in bytes
   typedef logic [`BUF_ADDR_W-1:0] byte_addr_t;

   // stored bytes, needs one more bit to reach a full buffer
   typedef logic [`BUF_ADDR_W:0] fill_t;

endpackage

`default_nettype wire

/* verilog/wconv_params.svh */
`ifndef WCONV_PARAMS_SVH
`define WCONV_PARAMS_SVH

// input byte width
`define BYTE_W 8

// output word width
`define WORD_W 32

// buffer size, in byte address space
`define BUF_ADDR_W 6
`define BUF_BYTES 64

`endif
